// File: hw/tex_cache_pkg.sv
// Texture cache shared definitions
package tex_cache_pkg;

	// ############################################################
	// address split
	// ############################################################

	// the memory port addresses bytes with this many bits.
	localparam int fml_depth = 26;

	// log2 of the cache capacity in bytes, which gives 8 KiB.
	localparam int cache_depth = 13;

	// log2 of the line size, one 4-beat burst of 64 bits.
	localparam int line_bits = 5;

	// a byte address splits into tag, line index and line offset.
	localparam int index_bits = cache_depth - line_bits;
	localparam int tag_bits = fml_depth - cache_depth;

	// the data memory holds whole 64-bit beats.
	localparam int beat_index_bits = cache_depth - 3;

	// ############################################################
	// payload types
	// ############################################################

	// texel addresses count 16-bit words, so they drop the byte bit.
	typedef logic [fml_depth-2:0] tex_adr_t;
	typedef logic [fml_depth-1:0] tex_byte_adr_t;

	typedef logic [15:0] texel_t;
	typedef logic [5:0] frac_t;

	// one memory beat holds four texels, the lowest address on top.
	typedef logic [63:0] tex_beat_t;

	// a bilinear request names the destination and the four corners.
	typedef struct packed {
		tex_adr_t dadr;
		tex_adr_t tadra;
		tex_adr_t tadrb;
		tex_adr_t tadrc;
		tex_adr_t tadrd;
		frac_t    x_frac;
		frac_t    y_frac;
	} tex_req_t;

	// the response carries the four colors, the rest passes through.
	typedef struct packed {
		tex_adr_t dadr;
		texel_t   tcolora;
		texel_t   tcolorb;
		texel_t   tcolorc;
		texel_t   tcolord;
		frac_t    x_frac;
		frac_t    y_frac;
	} tex_resp_t;

	// one tag memory entry.
	typedef struct packed {
		logic                valid;
		logic [tag_bits-1:0] tag;
	} tag_entry_t;

	// ############################################################
	// refill sequencing
	// ############################################################

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		DATA1 = 3'd1,
		DATA2 = 3'd2,
		DATA3 = 3'd3,
		DATA4 = 3'd4,
		WAIT1 = 3'd5,
		WAIT2 = 3'd6,
		FLUSH = 3'd7
	} refill_state_t;

endpackage

// File: hw/tex_quad_ram.sv
// Four-read one-write RAM
`timescale 1ns/1ps

module tex_quad_ram #(
	parameter type payload_t = logic [15:0],
	parameter int addr_bits = 8
) (
	input  logic                 sys_clk,

	input  logic [addr_bits-1:0] rd_adr_a_i,
	input  logic [addr_bits-1:0] rd_adr_b_i,
	input  logic [addr_bits-1:0] rd_adr_c_i,
	input  logic [addr_bits-1:0] rd_adr_d_i,
	output payload_t             rd_data_a_o,
	output payload_t             rd_data_b_o,
	output payload_t             rd_data_c_o,
	output payload_t             rd_data_d_o,

	input  logic                 we_i,
	input  logic [addr_bits-1:0] wr_adr_i,
	input  payload_t             wr_data_i
);

	payload_t mem [2**addr_bits];

	// a single write port, used by the refill and the flush.
	always_ff @(posedge sys_clk) begin
		if (we_i) begin
			mem[wr_adr_i] <= wr_data_i;
		end
	end

	// every corner gets its own read port.
	// a read that meets a write to the same entry returns the old value.
	always_ff @(posedge sys_clk) begin
		rd_data_a_o <= mem[rd_adr_a_i];
		rd_data_b_o <= mem[rd_adr_b_i];
		rd_data_c_o <= mem[rd_adr_c_i];
		rd_data_d_o <= mem[rd_adr_d_i];
	end

endmodule

// File: hw/tex_hit_check.sv
// Texture cache hit check
`timescale 1ns/1ps

module tex_hit_check import tex_cache_pkg::*; (
	input  logic                                sys_clk,
	input  logic                                sys_rst,

	input  logic                                req_stb_i,
	output logic                                req_ack_o,
	input  tex_req_t                            req_i,

	output logic                                resp_stb_o,
	input  logic                                resp_ack_i,
	output tex_resp_t                           resp_o,

	input  tag_entry_t                          tag_a_i,
	input  tag_entry_t                          tag_b_i,
	input  tag_entry_t                          tag_c_i,
	input  tag_entry_t                          tag_d_i,
	input  tex_beat_t                           beat_a_i,
	input  tex_beat_t                           beat_b_i,
	input  tex_beat_t                           beat_c_i,
	input  tex_beat_t                           beat_d_i,
	input  logic                                tag_we_i,

	output logic [3:0][index_bits-1:0]          tag_rd_adr_o,
	output logic [3:0][beat_index_bits-1:0]     data_rd_adr_o,
	output logic                                fetch_needed_o,
	output tex_byte_adr_t                       fetch_adr_o,
	output logic                                access_requested_o
);

	tex_req_t   req_q;
	logic       access_requested;
	logic       tag_we_seen;
	logic       retry;
	logic       all_hit;
	logic [3:0] ignore;
	logic [3:0] hit;
	tex_adr_t   new_adr [4];
	tex_adr_t   held_adr [4];
	tex_adr_t   rd_adr [4];
	tag_entry_t tag_rd [4];

	// the lane inside a beat comes from word address bits 1 and 0.
	// the lowest word sits in the top half of the beat.
	function automatic texel_t pick_texel(tex_beat_t beat, logic [1:0] lane);
		unique case (lane)
			2'd0: pick_texel = beat[63:48];
			2'd1: pick_texel = beat[47:32];
			2'd2: pick_texel = beat[31:16];
			default: pick_texel = beat[15:0];
		endcase
	endfunction

	// ############################################################
	// request register
	// ############################################################

	// the stage holds a request until all of its corners hit.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			access_requested <= 1'b0;
			tag_we_seen <= 1'b0;
		end else begin
			tag_we_seen <= tag_we_i;
			if (req_ack_o) begin
				access_requested <= req_stb_i;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (req_ack_o & req_stb_i) begin
			req_q <= req_i;
		end
	end

	// corners indexed 0 to 3 stand for A to D.
	always_comb begin
		new_adr[0] = req_i.tadra;
		new_adr[1] = req_i.tadrb;
		new_adr[2] = req_i.tadrc;
		new_adr[3] = req_i.tadrd;
		held_adr[0] = req_q.tadra;
		held_adr[1] = req_q.tadrb;
		held_adr[2] = req_q.tadrc;
		held_adr[3] = req_q.tadrd;
		tag_rd[0] = tag_a_i;
		tag_rd[1] = tag_b_i;
		tag_rd[2] = tag_c_i;
		tag_rd[3] = tag_d_i;
	end

	// ############################################################
	// tag compare
	// ############################################################

	// integer fractions make some corners unnecessary.
	// those corners count as hits and never start a refill.
	assign ignore[0] = 1'b0;
	assign ignore[1] = req_q.x_frac == '0;
	assign ignore[2] = req_q.y_frac == '0;
	assign ignore[3] = ignore[1] & ignore[2];

	// tags read in the cycle after a tag write may be stale, so that cycle misses.
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hit[i] = ignore[i] | (~tag_we_seen & tag_rd[i].valid
				& (tag_rd[i].tag == held_adr[i][fml_depth-2 -: tag_bits]));
		end
	end

	assign all_hit = &hit;
	assign resp_stb_o = access_requested & all_hit;
	assign req_ack_o = (resp_ack_i & resp_stb_o) | ~access_requested;
	assign access_requested_o = access_requested;

	// a held request reads its own lines again, whether it waits on a
	// refill or on back-pressure. otherwise the RAMs look up the new one.
	assign retry = access_requested & ~req_ack_o;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			rd_adr[i] = retry ? held_adr[i] : new_adr[i];
			tag_rd_adr_o[i] = rd_adr[i][cache_depth-2 -: index_bits];
			data_rd_adr_o[i] = rd_adr[i][cache_depth-2 -: beat_index_bits];
		end
	end

	// ############################################################
	// miss address
	// ############################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fetch_needed_o <= 1'b0;
		end else if (access_requested) begin
			fetch_needed_o <= ~all_hit;
		end
	end

	// the first missing corner in A to D order is refilled first.
	always_ff @(posedge sys_clk) begin
		if (access_requested) begin
			if (!hit[0]) begin
				fetch_adr_o <= {held_adr[0], 1'b0};
			end else if (!hit[1]) begin
				fetch_adr_o <= {held_adr[1], 1'b0};
			end else if (!hit[2]) begin
				fetch_adr_o <= {held_adr[2], 1'b0};
			end else if (!hit[3]) begin
				fetch_adr_o <= {held_adr[3], 1'b0};
			end
		end
	end

	// the response is built from the registered RAM outputs.
	always_comb begin
		resp_o.dadr = req_q.dadr;
		resp_o.tcolora = pick_texel(beat_a_i, req_q.tadra[1:0]);
		resp_o.tcolorb = pick_texel(beat_b_i, req_q.tadrb[1:0]);
		resp_o.tcolorc = pick_texel(beat_c_i, req_q.tadrc[1:0]);
		resp_o.tcolord = pick_texel(beat_d_i, req_q.tadrd[1:0]);
		resp_o.x_frac = req_q.x_frac;
		resp_o.y_frac = req_q.y_frac;
	end

endmodule

// File: hw/tex_fill_counter.sv
// Refill and flush address counters
`timescale 1ns/1ps

module tex_fill_counter import tex_cache_pkg::*; (
	input  logic                       sys_clk,
	input  logic                       beat_count_en_i,
	input  logic                       flush_mode_i,
	input  logic                       write_valid_i,
	input  tex_byte_adr_t              fetch_adr_i,

	output logic [index_bits-1:0]      tag_wr_adr_o,
	output tag_entry_t                 tag_wr_data_o,
	output logic [beat_index_bits-1:0] data_wr_adr_o,
	output tex_byte_adr_t              fml_adr_o,
	output logic                       flush_done_o
);

	logic [1:0]            beat_count;
	logic [index_bits-1:0] flush_index;
	logic [index_bits-1:0] line_index;

	// the beat counter steps once per received beat of a burst.
	always_ff @(posedge sys_clk) begin
		if (beat_count_en_i) begin
			beat_count <= beat_count + 2'd1;
		end else begin
			beat_count <= '0;
		end
	end

	// the flush walks every line index once.
	always_ff @(posedge sys_clk) begin
		if (flush_mode_i) begin
			flush_index <= flush_index + 1'b1;
		end else begin
			flush_index <= '0;
		end
	end

	assign flush_done_o = &flush_index;
	assign line_index = fetch_adr_i[cache_depth-1 -: index_bits];

	// a refill writes the fetched line, a flush writes each index in turn.
	assign tag_wr_adr_o = flush_mode_i ? flush_index : line_index;
	assign tag_wr_data_o.valid = write_valid_i;
	assign tag_wr_data_o.tag = fetch_adr_i[fml_depth-1 -: tag_bits];

	assign data_wr_adr_o = {line_index, beat_count};

	// bursts always start on a line boundary.
	assign fml_adr_o = {fetch_adr_i[fml_depth-1:line_bits], {line_bits{1'b0}}};

endmodule

// File: hw/tex_refill_fsm.sv
// Refill and flush FSM
`timescale 1ns/1ps

module tex_refill_fsm import tex_cache_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic fetch_needed_i,
	input  logic flush_i,
	input  logic fml_ack_i,
	input  logic flush_done_i,
	input  logic access_requested_i,

	output logic fml_stb_o,
	output logic data_we_o,
	output logic tag_we_o,
	output logic write_valid_o,
	output logic beat_count_en_o,
	output logic flush_mode_o,
	output logic busy_o
);

	refill_state_t state;
	refill_state_t next_state;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		fml_stb_o = 1'b0;
		data_we_o = 1'b0;
		tag_we_o = 1'b0;
		write_valid_o = 1'b1;
		beat_count_en_o = 1'b0;
		flush_mode_o = 1'b0;

		unique case (state)
			// a flush wins over a pending fetch.
			IDLE: begin
				if (flush_i) begin
					next_state = FLUSH;
				end else if (fetch_needed_i) begin
					next_state = DATA1;
				end
			end
			// beat 0 arrives with the acknowledge.
			// the write is enabled but only lands once the ack comes.
			DATA1: begin
				fml_stb_o = 1'b1;
				data_we_o = fml_ack_i;
				if (fml_ack_i) begin
					beat_count_en_o = 1'b1;
					next_state = DATA2;
				end
			end
			DATA2: begin
				data_we_o = 1'b1;
				beat_count_en_o = 1'b1;
				next_state = DATA3;
			end
			DATA3: begin
				data_we_o = 1'b1;
				beat_count_en_o = 1'b1;
				next_state = DATA4;
			end
			// the tag goes in with the last beat.
			// it may release the held request.
			DATA4: begin
				data_we_o = 1'b1;
				tag_we_o = 1'b1;
				next_state = WAIT1;
			end
			// fetch_needed takes two cycles to see the new tag.
			WAIT1: begin
				next_state = WAIT2;
			end
			WAIT2: begin
				next_state = IDLE;
			end
			FLUSH: begin
				tag_we_o = 1'b1;
				write_valid_o = 1'b0;
				flush_mode_o = 1'b1;
				if (flush_done_i) begin
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// a request still in the hit stage also keeps the cache busy.
	assign busy_o = (state != IDLE) | access_requested_i;

endmodule

// File: hw/tex_cache_top.sv
// Texture cache top level
`timescale 1ns/1ps

module tex_cache_top import tex_cache_pkg::*; (
	input  logic          sys_clk,
	input  logic          sys_rst,

	input  logic          flush_i,
	output logic          busy_o,

	input  logic          req_stb_i,
	output logic          req_ack_o,
	input  tex_req_t      req_i,

	output logic          resp_stb_o,
	input  logic          resp_ack_i,
	output tex_resp_t     resp_o,

	output tex_byte_adr_t fml_adr_o,
	output logic          fml_stb_o,
	input  logic          fml_ack_i,
	input  tex_beat_t     fml_di_i
);

	logic [3:0][index_bits-1:0]      tag_rd_adr;
	logic [3:0][beat_index_bits-1:0] data_rd_adr;
	tag_entry_t                      tag_rd [4];
	tex_beat_t                       beat_rd [4];

	logic                            tag_we;
	logic [index_bits-1:0]           tag_wr_adr;
	tag_entry_t                      tag_wr_data;
	logic                            data_we;
	logic [beat_index_bits-1:0]      data_wr_adr;

	logic                            fetch_needed;
	tex_byte_adr_t                   fetch_adr;
	logic                            access_requested;
	logic                            write_valid;
	logic                            beat_count_en;
	logic                            flush_mode;
	logic                            flush_done;

	// ############################################################
	// memories
	// ############################################################

	tex_quad_ram #(
		.payload_t(tag_entry_t),
		.addr_bits(index_bits)
	) tag_ram (
		.sys_clk(sys_clk),
		.rd_adr_a_i(tag_rd_adr[0]),
		.rd_adr_b_i(tag_rd_adr[1]),
		.rd_adr_c_i(tag_rd_adr[2]),
		.rd_adr_d_i(tag_rd_adr[3]),
		.rd_data_a_o(tag_rd[0]),
		.rd_data_b_o(tag_rd[1]),
		.rd_data_c_o(tag_rd[2]),
		.rd_data_d_o(tag_rd[3]),
		.we_i(tag_we),
		.wr_adr_i(tag_wr_adr),
		.wr_data_i(tag_wr_data)
	);

	// memory beats are stored as they arrive.
	tex_quad_ram #(
		.payload_t(tex_beat_t),
		.addr_bits(beat_index_bits)
	) data_ram (
		.sys_clk(sys_clk),
		.rd_adr_a_i(data_rd_adr[0]),
		.rd_adr_b_i(data_rd_adr[1]),
		.rd_adr_c_i(data_rd_adr[2]),
		.rd_adr_d_i(data_rd_adr[3]),
		.rd_data_a_o(beat_rd[0]),
		.rd_data_b_o(beat_rd[1]),
		.rd_data_c_o(beat_rd[2]),
		.rd_data_d_o(beat_rd[3]),
		.we_i(data_we),
		.wr_adr_i(data_wr_adr),
		.wr_data_i(fml_di_i)
	);

	// ############################################################
	// control
	// ############################################################

	tex_hit_check u_hit_check (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.req_stb_i(req_stb_i),
		.req_ack_o(req_ack_o),
		.req_i(req_i),
		.resp_stb_o(resp_stb_o),
		.resp_ack_i(resp_ack_i),
		.resp_o(resp_o),
		.tag_a_i(tag_rd[0]),
		.tag_b_i(tag_rd[1]),
		.tag_c_i(tag_rd[2]),
		.tag_d_i(tag_rd[3]),
		.beat_a_i(beat_rd[0]),
		.beat_b_i(beat_rd[1]),
		.beat_c_i(beat_rd[2]),
		.beat_d_i(beat_rd[3]),
		.tag_we_i(tag_we),
		.tag_rd_adr_o(tag_rd_adr),
		.data_rd_adr_o(data_rd_adr),
		.fetch_needed_o(fetch_needed),
		.fetch_adr_o(fetch_adr),
		.access_requested_o(access_requested)
	);

	tex_fill_counter u_fill_counter (
		.sys_clk(sys_clk),
		.beat_count_en_i(beat_count_en),
		.flush_mode_i(flush_mode),
		.write_valid_i(write_valid),
		.fetch_adr_i(fetch_adr),
		.tag_wr_adr_o(tag_wr_adr),
		.tag_wr_data_o(tag_wr_data),
		.data_wr_adr_o(data_wr_adr),
		.fml_adr_o(fml_adr_o),
		.flush_done_o(flush_done)
	);

	tex_refill_fsm u_refill_fsm (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.fetch_needed_i(fetch_needed),
		.flush_i(flush_i),
		.fml_ack_i(fml_ack_i),
		.flush_done_i(flush_done),
		.access_requested_i(access_requested),
		.fml_stb_o(fml_stb_o),
		.data_we_o(data_we),
		.tag_we_o(tag_we),
		.write_valid_o(write_valid),
		.beat_count_en_o(beat_count_en),
		.flush_mode_o(flush_mode),
		.busy_o(busy_o)
	);

endmodule

// File: dv/tex_cache_checker.sv
// Texture cache response checker
`timescale 1ns/1ps

module tex_cache_checker import tex_cache_pkg::*; (
	input  logic          sys_clk,
	input  logic          sys_rst,

	input  logic          req_stb_i,
	input  logic          req_ack_i,
	input  tex_req_t      req_i,
	input  logic [3:0]    exp_bursts_i,

	input  logic          resp_stb_i,
	input  logic          resp_ack_i,
	input  tex_resp_t     resp_i,

	input  logic          fml_stb_i,
	input  logic          fml_ack_i,
	input  tex_byte_adr_t fml_adr_i,
	input  logic          busy_i,

	input  logic          finish_i,
	output int            errors_o
);

	tex_resp_t  exp_q [$];
	logic [3:0] skip_q [$];
	tex_resp_t  exp_resp;
	logic [3:0] skip;
	int         n_req;
	int         n_resp;
	int         n_burst;
	int         errors;
	logic       have_cur;
	int         cur_bursts;
	int         cur_exp;
	logic       rst_q;

	initial begin
		n_req = 0;
		n_resp = 0;
		n_burst = 0;
		errors = 0;
		have_cur = 1'b0;
		cur_bursts = 0;
		cur_exp = 0;
		rst_q = 1'b1;
	end

	assign errors_o = errors;

	// memory contents are defined per 16-bit word address.
	function automatic texel_t texel_rule(tex_adr_t w);
		return w[15:0] ^ 16'h5a5a;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// the bursts seen while a request sat in the hit stage belong to it.
	task automatic close_request();
		if (have_cur) begin
			check_value("fml_stb_o bursts", cur_bursts, cur_exp);
		end
		have_cur = 1'b0;
	endtask

	// ############################################################
	// per-edge monitor
	// ############################################################

	// all values read here are the ones that stood before the edge.
	always @(posedge sys_clk) begin
		rst_q <= sys_rst;
		if (!sys_rst) begin
			// the first edge out of reset shows the reset state.
			if (rst_q) begin
				check_value("fml_stb_o", fml_stb_i, 0);
				check_value("resp_stb_o", resp_stb_i, 0);
				check_value("busy_o", busy_i, 0);
			end
			if (fml_stb_i && fml_ack_i) begin
				n_burst++;
				cur_bursts++;
				check_value("fml_adr_o offset", fml_adr_i[line_bits-1:0], 0);
			end
			if (resp_stb_i && resp_ack_i) begin
				n_resp++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("a response came out with no request waiting for it");
				end else begin
					exp_resp = exp_q.pop_front();
					skip = skip_q.pop_front();
					check_value("resp_o.dadr", resp_i.dadr, exp_resp.dadr);
					check_value("resp_o.x_frac", resp_i.x_frac, exp_resp.x_frac);
					check_value("resp_o.y_frac", resp_i.y_frac, exp_resp.y_frac);
					check_value("resp_o.tcolora", resp_i.tcolora, exp_resp.tcolora);
					// skipped corners carry whatever the RAM held.
					if (!skip[1]) begin
						check_value("resp_o.tcolorb", resp_i.tcolorb, exp_resp.tcolorb);
					end
					if (!skip[2]) begin
						check_value("resp_o.tcolorc", resp_i.tcolorc, exp_resp.tcolorc);
					end
					if (!skip[3]) begin
						check_value("resp_o.tcolord", resp_i.tcolord, exp_resp.tcolord);
					end
				end
			end
			if (req_stb_i && req_ack_i) begin
				close_request();
				n_req++;
				exp_resp.dadr = req_i.dadr;
				exp_resp.tcolora = texel_rule(req_i.tadra);
				exp_resp.tcolorb = texel_rule(req_i.tadrb);
				exp_resp.tcolorc = texel_rule(req_i.tadrc);
				exp_resp.tcolord = texel_rule(req_i.tadrd);
				exp_resp.x_frac = req_i.x_frac;
				exp_resp.y_frac = req_i.y_frac;
				// a zero x fraction drops B, a zero y drops C, both drop D.
				skip[0] = 1'b0;
				skip[1] = req_i.x_frac == 6'd0;
				skip[2] = req_i.y_frac == 6'd0;
				skip[3] = skip[1] & skip[2];
				exp_q.push_back(exp_resp);
				skip_q.push_back(skip);
				have_cur = 1'b1;
				cur_bursts = 0;
				cur_exp = exp_bursts_i;
			end
		end
	end

	// ############################################################
	// closing report
	// ############################################################

	always @(posedge finish_i) begin
		close_request();
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d requests never got a response", exp_q.size());
		end
		$display("checker: %0d requests, %0d responses, %0d bursts, %0d errors",
			n_req, n_resp, n_burst, errors);
	end

endmodule

// File: dv/tb_tex_cache.sv
// Texture cache testbench
`timescale 1ns/1ps

module tb_tex_cache import tex_cache_pkg::*; ();

	localparam int req_limit = 300;
	localparam int idle_limit = 600;

	logic          sys_clk;
	logic          sys_rst;
	logic          flush;
	logic          busy;
	logic          req_stb;
	logic          req_ack;
	tex_req_t      req;
	logic          resp_stb;
	logic          resp_ack;
	tex_resp_t     resp;
	tex_byte_adr_t fml_adr;
	logic          fml_stb;
	logic          fml_ack;
	tex_beat_t     fml_di;

	logic [3:0]    exp_bursts;
	logic          finish_chk;
	int            chk_errors;
	logic          aborted;
	string         abort_reason;

	tex_cache_top dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush),
		.busy_o(busy),
		.req_stb_i(req_stb),
		.req_ack_o(req_ack),
		.req_i(req),
		.resp_stb_o(resp_stb),
		.resp_ack_i(resp_ack),
		.resp_o(resp),
		.fml_adr_o(fml_adr),
		.fml_stb_o(fml_stb),
		.fml_ack_i(fml_ack),
		.fml_di_i(fml_di)
	);

	tex_cache_checker chk (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.req_stb_i(req_stb),
		.req_ack_i(req_ack),
		.req_i(req),
		.exp_bursts_i(exp_bursts),
		.resp_stb_i(resp_stb),
		.resp_ack_i(resp_ack),
		.resp_i(resp),
		.fml_stb_i(fml_stb),
		.fml_ack_i(fml_ack),
		.fml_adr_i(fml_adr),
		.busy_i(busy),
		.finish_i(finish_chk),
		.errors_o(chk_errors)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// ############################################################
	// memory model
	// ############################################################

	// a beat holds four consecutive words, the lowest in the top lane.
	function automatic tex_beat_t make_beat(tex_byte_adr_t line_adr, int k);
		tex_beat_t beat;
		tex_adr_t  w;
		for (int i = 0; i < 4; i++) begin
			w = line_adr[fml_depth-1:1] + tex_adr_t'(4 * k + i);
			beat[63 - 16 * i -: 16] = w[15:0] ^ 16'h5a5a;
		end
		return beat;
	endfunction

	// beat 0 comes with the acknowledge, the other three follow back to back.
	initial begin : memory_model
		tex_byte_adr_t adr;
		int            delay;
		fml_ack = 1'b0;
		fml_di = '0;
		forever begin
			@(posedge sys_clk);
			if (fml_stb && !sys_rst) begin
				adr = fml_adr;
				delay = $urandom % 4;
				repeat (delay) @(posedge sys_clk);
				fml_ack <= 1'b1;
				fml_di <= make_beat(adr, 0);
				for (int k = 1; k < 4; k++) begin
					@(posedge sys_clk);
					fml_ack <= 1'b0;
					fml_di <= make_beat(adr, k);
				end
				@(posedge sys_clk);
				fml_di <= '0;
			end
		end
	end

	// the downstream stage refuses about one response in three.
	initial begin : back_pressure
		resp_ack = 1'b0;
		forever begin
			@(posedge sys_clk);
			resp_ack <= ($urandom % 3) != 0;
		end
	end

	// ############################################################
	// stimulus tasks
	// ############################################################

	// holds the request until the cache takes it.
	task automatic send_request(input tex_req_t r, input logic [3:0] nb);
		int n;
		req_stb <= 1'b1;
		req <= r;
		exp_bursts <= nb;
		n = 0;
		forever begin
			@(posedge sys_clk);
			if (req_ack) begin
				break;
			end
			n++;
			if (n >= req_limit) begin
				aborted = 1'b1;
				abort_reason = "a request was never accepted";
				break;
			end
		end
		req_stb <= 1'b0;
	endtask

	// waits until no request is held and the refill FSM is idle.
	task automatic wait_idle(input string what);
		int n;
		n = 0;
		forever begin
			@(posedge sys_clk);
			if (!busy) begin
				break;
			end
			n++;
			if (n >= idle_limit) begin
				aborted = 1'b1;
				abort_reason = what;
				break;
			end
		end
	endtask

	task automatic do_flush();
		wait_idle("the cache stayed busy before a flush");
		if (!aborted) begin
			flush <= 1'b1;
			@(posedge sys_clk);
			flush <= 1'b0;
			wait_idle("busy did not fall after a flush");
		end
	endtask

	// ############################################################
	// main sequence
	// ############################################################

	initial begin : stimulus
		int         fd;
		int         code;
		int         n_fields;
		string      line;
		tex_req_t   r;
		tex_adr_t   dadr;
		tex_adr_t   a;
		tex_adr_t   b;
		tex_adr_t   c;
		tex_adr_t   d;
		logic [5:0] xf;
		logic [5:0] yf;
		logic [3:0] nb;
		void'($urandom(32'h0fec_3d6b));
		sys_rst = 1'b1;
		flush = 1'b0;
		req_stb = 1'b0;
		req = '0;
		exp_bursts = '0;
		finish_chk = 1'b0;
		aborted = 1'b0;
		abort_reason = "";

		repeat (4) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);

		// the tag memory has no reset, so its lines start out invalid only after a flush.
		do_flush();

		fd = $fopen("dv/tex_cache_tests.txt", "r");
		if (fd == 0) begin
			aborted = 1'b1;
			abort_reason = "the test file could not be opened";
		end else begin
			while (!aborted && !$feof(fd)) begin
				code = $fgets(line, fd);
				if (code == 0 || line.len() < 1) begin
					continue;
				end
				// lines that start with anything else are comments.
				if (line.getc(0) == "F") begin
					do_flush();
				end else if (line.getc(0) == "R") begin
					n_fields = $sscanf(line.substr(1, line.len() - 1),
						"%h %h %h %h %h %h %h %d", dadr, a, b, c, d, xf, yf, nb);
					if (n_fields != 8) begin
						aborted = 1'b1;
						abort_reason = "a request line in the test file is malformed";
					end else begin
						r.dadr = dadr;
						r.tadra = a;
						r.tadrb = b;
						r.tadrc = c;
						r.tadrd = d;
						r.x_frac = xf;
						r.y_frac = yf;
						send_request(r, nb);
					end
				end
			end
			$fclose(fd);
		end

		if (!aborted) begin
			wait_idle("the last responses never drained");
		end
		finish_chk = 1'b1;
		#1;
		if (aborted) begin
			$display("run aborted: %s", abort_reason);
		end
		if (aborted || chk_errors != 0) begin
			$display("Done: errors found");
		end else begin
			$display("Done: no errors");
		end
		$finish;
	end

endmodule

// File: dv/tex_cache_tests.txt
# R dadr tadra tadrb tadrc tadrd x_frac y_frac bursts (hex, bursts decimal)
# F flushes every tag; addresses are 16-bit word addresses
R 000100 001000 001001 001010 001011 20 20 2
R 000101 001002 001003 001012 001013 11 05 0
R 000102 001004 001008 00100c 00100f 01 01 0
R 000103 002040 005080 0020c0 0020c1 00 10 2
R 000104 002044 002045 006100 001011 07 00 0
R 000105 007200 007300 007400 007500 00 00 1
R 000106 005080 005081 007300 007301 3f 3f 2
R 000107 007200 007203 0020c2 001000 3f 01 0
R 000108 00b000 00b001 00b010 00b011 01 01 2
R 000109 001000 001001 001010 001011 01 01 2
F
R 00010a 001000 001001 001010 001011 01 01 2
R 00010b 002040 005080 0020c0 0020c1 01 01 3
R 00010c 001003 001002 001013 001012 2a 15 0
R 00010d 002041 005083 0020c3 0020c2 02 02 0
R 00010e 007301 007302 005082 002042 0a 0b 1
R 00010f 00100e 00101f 00204f 00508f 01 3f 0
R 000110 1fff800 1fff801 1fff810 1fff811 01 01 2
R 000111 1fff803 1fff80e 1fff81d 1fff81c 01 01 0
F
R 000112 1fff803 1fff80e 1fff81d 1fff81c 01 01 2
R 000113 1fff802 1fff80f 1fff81e 1fff81f 30 01 0

// File: sim.f
hw/tex_cache_pkg.sv
hw/tex_quad_ram.sv
hw/tex_hit_check.sv
hw/tex_fill_counter.sv
hw/tex_refill_fsm.sv
hw/tex_cache_top.sv
dv/tex_cache_checker.sv
dv/tb_tex_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tex_cache
RTL_TOP   ?= tex_cache_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation incomplete"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing \
		hw/tex_cache_pkg.sv hw/tex_quad_ram.sv hw/tex_hit_check.sv \
		hw/tex_fill_counter.sv hw/tex_refill_fsm.sv hw/tex_cache_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
